// File: ooo_issue.f
rtl/ooo_pkg.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/ooo_issue_top.sv
tests/ooo_issue_chk.sv
tests/ooo_issue_tb.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  # package first, every other file imports it
  - rtl/ooo_pkg.sv
  - rtl/reservation_station.sv
  - rtl/alu_unit.sv
  - rtl/ooo_issue_top.sv
  - target: test
    files:
      - tests/ooo_issue_chk.sv
      - tests/ooo_issue_tb.sv

// File: tests/ooo_issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_issue_tb import ooo_pkg::*; ();

    localparam int max_cycles = 400; // generous bound for the whole run

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   load;
    logic                   issue_enable;
    alu_func_t              func;
    logic [rob_tag_len-1:0] t1;
    logic [rob_tag_len-1:0] t2;
    logic [rob_tag_len-1:0] dst;
    logic                   ready1;
    logic                   ready2;
    logic [xlen-1:0]        v1;
    logic [xlen-1:0]        v2;
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        imm;
    logic                   is_full;
    logic                   result_valid;
    logic [rob_tag_len-1:0] result_tag;
    logic [xlen-1:0]        result_value;

    int                     cycle_count = 0;
    logic [rob_tag_len-1:0] exp_tag [$];   // results the model predicts, in order
    logic [xlen-1:0]        exp_value [$];
    logic [rob_tag_len-1:0] got_tag [$];   // results seen on the bus
    logic [xlen-1:0]        got_value [$];
    int                     got_cycle [$]; // cycle number of each seen result

    ooo_issue_top u_ooo_issue_top (.*);

    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            abort_run("timeout, the run went past its cycle limit");
        end
    end

    // the bus is read a quarter period after the edge where it has settled
    always @(posedge clk) begin
        #25;
        if (result_valid === 1'b1) begin
            got_tag.push_back(result_tag);
            got_value.push_back(result_value);
            got_cycle.push_back(cycle_count);
        end
    end

    always @(negedge clk) begin
        if (u_ooo_issue_top.u_station.u_chk.assert_failures != 0) begin
            abort_run("a concurrent assertion on the station failed");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // reference alu, straight from the function code rules
    function automatic logic [xlen-1:0] model_result(alu_func_t f, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b, logic [xlen-1:0] p,
                                                     logic [xlen-1:0] i);
        case (f)
            alu_add:   return a + b;
            alu_sub:   return a - b;
            alu_and:   return a & b;
            alu_or:    return a | b;
            alu_xor:   return a ^ b;
            alu_slt:   return ($signed(a) < $signed(b)) ? xlen'(1) : xlen'(0);
            alu_mul:   return a * b; // low half of the product
            default:   return p + i; // auipc
        endcase
    endfunction

    // one load strobe, dep_sel 1 or 2 makes that source wait for dep_tag
    task automatic load_insn(input alu_func_t f, input logic [rob_tag_len-1:0] d,
                             input int dep_sel, input logic [rob_tag_len-1:0] dep_tag,
                             input logic [xlen-1:0] dep_value, input bit wait_free,
                             input bit expected, output logic [xlen-1:0] result);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = $urandom();
        b = $urandom();
        while (wait_free && is_full) begin
            @(negedge clk); // dispatcher holds the instruction and retries
        end
        load = 1'b1;
        func = f;
        dst = d;
        t1 = dep_tag;
        t2 = dep_tag;           // only matters for a source that waits
        ready1 = (dep_sel != 1);
        ready2 = (dep_sel != 2);
        v1 = a;                 // junk for a waiting source until its wakeup
        v2 = b;
        pc = $urandom();
        imm = $urandom();
        result = model_result(f, (dep_sel == 1) ? dep_value : a,
                              (dep_sel == 2) ? dep_value : b, pc, imm);
        if (expected) begin
            exp_tag.push_back(d);
            exp_value.push_back(result);
        end
        @(negedge clk);
        load = 1'b0;
    endtask

    // the global cycle counter bounds this wait
    task automatic collect_results();
        while (got_tag.size() < exp_tag.size()) begin
            @(negedge clk);
        end
        while (exp_tag.size() != 0) begin
            check_value("result_tag", exp_tag.pop_front(), got_tag.pop_front());
            check_value("result_value", exp_value.pop_front(), got_value.pop_front());
            void'(got_cycle.pop_front());
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        check_value("result count", 0, got_tag.size());
    endtask

    task automatic reset_state_quiet();
        check_value("is_full", 0, is_full);
        check_value("result_valid", 0, result_valid);
        expect_quiet(5); // nothing loaded yet, so the bus stays idle
    endtask

    task automatic every_function_code();
        logic [xlen-1:0] r;
        for (int k = 0; k < 8; k++) begin
            load_insn(alu_func_t'(k), rob_tag_len'(1 + k), 0, '0, '0, 1'b1, 1'b1, r);
        end
        collect_results();
    endtask

    task automatic dependent_chain();
        alu_func_t       kinds [4] = '{alu_add, alu_mul, alu_sub, alu_xor};
        logic [xlen-1:0] r;
        load_insn(kinds[0], rob_tag_len'(10), 0, '0, '0, 1'b1, 1'b1, r);
        for (int k = 1; k < 4; k++) begin
            // odd steps wait on the first source and even ones on the second
            load_insn(kinds[k], rob_tag_len'(10 + k), (k % 2) ? 1 : 2,
                      rob_tag_len'(9 + k), r, 1'b1, 1'b1, r);
        end
        collect_results();
    endtask

    task automatic full_station_drop();
        alu_func_t       kinds [4] = '{alu_and, alu_or, alu_slt, alu_sub};
        logic [xlen-1:0] r;
        issue_enable = 1'b0;
        for (int k = 0; k < 4; k++) begin
            load_insn(kinds[k], rob_tag_len'(20 + k), 0, '0, '0, 1'b1, 1'b1, r);
        end
        check_value("is_full", 1, is_full);
        load_insn(alu_add, rob_tag_len'(24), 0, '0, '0, 1'b0, 1'b0, r); // must be dropped
        check_value("is_full", 1, is_full);
        expect_quiet(2);
        issue_enable = 1'b1;
        collect_results();
        expect_quiet(8); // tag 24 never shows up
    endtask

    task automatic oldest_first_release();
        logic [xlen-1:0] r;
        issue_enable = 1'b0;
        load_insn(alu_add, rob_tag_len'(30), 0, '0, '0, 1'b1, 1'b1, r);
        load_insn(alu_xor, rob_tag_len'(31), 0, '0, '0, 1'b1, 1'b1, r);
        load_insn(alu_auipc, rob_tag_len'(32), 0, '0, '0, 1'b1, 1'b1, r);
        issue_enable = 1'b1; // a single issue edge frees slot 0
        @(negedge clk);
        issue_enable = 1'b0;
        load_insn(alu_or, rob_tag_len'(33), 0, '0, '0, 1'b1, 1'b1, r); // lowest slot, youngest age
        issue_enable = 1'b1;
        collect_results();
    endtask

    task automatic multiply_spacing();
        alu_func_t       kinds [4] = '{alu_add, alu_mul, alu_mul, alu_sub};
        logic [xlen-1:0] r;
        int              slot;
        int              due [4];
        slot = 0;
        issue_enable = 1'b0;
        for (int k = 0; k < 4; k++) begin
            load_insn(kinds[k], rob_tag_len'(40 + k), 0, '0, '0, 1'b1, 1'b1, r);
            // a multiply takes the bus one slot late and the next issue waits for it
            due[k] = slot + ((kinds[k] == alu_mul) ? 2 : 1);
            slot = due[k];
        end
        issue_enable = 1'b1;
        while (got_tag.size() < 4) begin
            @(negedge clk);
        end
        for (int k = 1; k < 4; k++) begin
            check_value("result spacing", due[k] - due[0], got_cycle[k] - got_cycle[0]);
        end
        collect_results();
    endtask

    initial begin
        void'($urandom(32'heca6)); // one seed for the whole run
        reset = 1'b1;
        load = 1'b0;
        issue_enable = 1'b1;
        func = alu_add;
        t1 = '0;
        t2 = '0;
        dst = '0;
        ready1 = 1'b0;
        ready2 = 1'b0;
        v1 = '0;
        v2 = '0;
        pc = '0;
        imm = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        reset_state_quiet();
        every_function_code();
        dependent_chain();
        full_station_drop();
        oldest_first_release();
        multiply_spacing();
        expect_quiet(4);
        if (u_ooo_issue_top.u_station.u_chk.assert_failures != 0) begin
            abort_run("a concurrent assertion on the station failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/ooo_issue_chk.sv
`timescale 1ns/1ns
`default_nettype none

// concurrent properties on the reservation station and its handoff to the alu
module ooo_issue_chk import ooo_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      start,
    input logic      issue,
    input logic      insn_ready,
    input logic      is_full,
    input alu_func_t func_out,
    input rs_entry_t entries [num_entries]
);

    int   assert_failures = 0; // polled by the testbench
    logic all_valid;           // no slot is free

    always_comb begin
        all_valid = 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            all_valid = all_valid && entries[i].valid;
        end
    end

    // the cycle after a multiply starts belongs to its product on the result bus
    mul_gap: assert property (@(posedge clk) disable iff (reset)
        start && (func_out == alu_mul) |=> !start)
        else begin
            assert_failures++;
            $error("start was high in the cycle after a multiply started");
        end

    full_no_free: assert property (@(posedge clk) disable iff (reset) is_full |-> all_valid)
        else begin
            assert_failures++;
            $error("is_full is high while a station slot is free");
        end

    // start is only the registered copy of an issue that had a ready entry
    start_after_issue: assert property (@(posedge clk) disable iff (reset)
        start |-> $past(issue && insn_ready))
        else begin
            assert_failures++;
            $error("start without an issue of a ready entry in the cycle before");
        end

endmodule

bind reservation_station ooo_issue_chk u_chk (
    .clk, .reset, .start, .issue, .insn_ready, .is_full, .func_out, .entries
);

`default_nettype wire

// File: rtl/ooo_issue_top.sv
`timescale 1ns/1ns
`default_nettype none

// issue stage: one reservation station feeding one alu, whose broadcast is
// both the wakeup and the result
module ooo_issue_top import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   issue_enable,
    input  alu_func_t              func,
    input  logic [rob_tag_len-1:0] t1,
    input  logic [rob_tag_len-1:0] t2,
    input  logic [rob_tag_len-1:0] dst,
    input  logic                   ready1,
    input  logic                   ready2,
    input  logic [xlen-1:0]        v1,
    input  logic [xlen-1:0]        v2,
    input  logic [xlen-1:0]        pc,
    input  logic [xlen-1:0]        imm,
    output logic                   is_full,
    output logic                   result_valid, // also the wakeup strobe
    output logic [rob_tag_len-1:0] result_tag,
    output logic [xlen-1:0]        result_value
);

    logic                   insn_ready;
    logic                   issue;
    logic                   start;
    alu_func_t              func_out;
    logic [xlen-1:0]        v1_out;
    logic [xlen-1:0]        v2_out;
    logic [xlen-1:0]        pc_out;
    logic [xlen-1:0]        imm_out;
    logic [rob_tag_len-1:0] dst_out;

    reservation_station u_station (
        .clk, .reset, .load, .issue,
        .wakeup(result_valid),
        .func, .t1, .t2, .dst, .ready1, .ready2, .v1, .v2, .pc, .imm,
        .wakeup_tag(result_tag),
        .wakeup_value(result_value),
        .insn_ready, .is_full, .start,
        .func_out, .v1_out, .v2_out, .pc_out, .imm_out, .dst_out
    );

    // the result bus goes straight back into the station as its wakeup
    alu_unit u_alu (
        .clk, .reset, .start, .insn_ready, .issue_enable,
        .func_out, .v1_out, .v2_out, .pc_out, .imm_out, .dst_out,
        .issue,
        .wakeup(result_valid),
        .wakeup_tag(result_tag),
        .wakeup_value(result_value)
    );

endmodule

`default_nettype wire

// File: rtl/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

// integer alu behind the station, it also owns the issue decision and the
// single result bus that doubles as the wakeup
module alu_unit import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,        // operands below are valid this cycle
    input  logic                   insn_ready,
    input  logic                   issue_enable, // external stall when low
    input  alu_func_t              func_out,
    input  logic [xlen-1:0]        v1_out,
    input  logic [xlen-1:0]        v2_out,
    input  logic [xlen-1:0]        pc_out,
    input  logic [xlen-1:0]        imm_out,
    input  logic [rob_tag_len-1:0] dst_out,
    output logic                   issue,
    output logic                   wakeup,
    output logic [rob_tag_len-1:0] wakeup_tag,
    output logic [xlen-1:0]        wakeup_value
);

    logic [xlen-1:0]        alu_result;  // single cycle result, or the product for a multiply
    logic                   mul_start;   // a multiply is in its first cycle
    logic                   mul_hold;
    logic                   mul_pending; // product waits in the second stage
    logic [xlen-1:0]        mul_value;
    logic [rob_tag_len-1:0] mul_tag;

    always_comb begin
        case (func_out)
            alu_add:   alu_result = v1_out + v2_out;
            alu_sub:   alu_result = v1_out - v2_out;
            alu_and:   alu_result = v1_out & v2_out;
            alu_or:    alu_result = v1_out | v2_out;
            alu_xor:   alu_result = v1_out ^ v2_out;
            alu_slt:   alu_result = ($signed(v1_out) < $signed(v2_out)) ? xlen'(1) : '0;
            alu_mul:   alu_result = v1_out * v2_out; // low half of the product only
            alu_auipc: alu_result = pc_out + imm_out;
            default:   alu_result = '0;
        endcase
    end

    assign mul_start = start && (func_out == alu_mul);

    // the cycle after a multiply belongs to its product, so nothing issues
    // at the edge that would put a second result on the bus then
    assign mul_hold = mul_start;
    assign issue    = insn_ready && issue_enable && !mul_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_pending <= 1'b0;
        end else begin
            mul_pending <= mul_start;
        end
    end

    // second stage of the multiply keeps only data
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_value <= alu_result;
            mul_tag   <= dst_out;
        end
    end

    // the two sources never overlap because of mul_hold
    assign wakeup       = (start && !mul_start) || mul_pending;
    assign wakeup_tag   = mul_pending ? mul_tag : dst_out;
    assign wakeup_value = mul_pending ? mul_value : alu_result;

endmodule

`default_nettype wire

// File: rtl/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

// holds renamed instructions until both operands are known, then hands the
// oldest ready one to the alu
module reservation_station import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,         // dispatch strobe
    input  logic                   issue,        // from the alu, already qualified
    input  logic                   wakeup,       // result broadcast valid
    input  alu_func_t              func,
    input  logic [rob_tag_len-1:0] t1,
    input  logic [rob_tag_len-1:0] t2,
    input  logic [rob_tag_len-1:0] dst,
    input  logic                   ready1,
    input  logic                   ready2,
    input  logic [xlen-1:0]        v1,
    input  logic [xlen-1:0]        v2,
    input  logic [xlen-1:0]        pc,
    input  logic [xlen-1:0]        imm,
    input  logic [rob_tag_len-1:0] wakeup_tag,
    input  logic [xlen-1:0]        wakeup_value,
    output logic                   insn_ready,   // some entry could issue this cycle
    output logic                   is_full,      // dispatcher has to hold and retry
    output logic                   start,        // one cycle pulse towards the alu
    output alu_func_t              func_out,
    output logic [xlen-1:0]        v1_out,
    output logic [xlen-1:0]        v2_out,
    output logic [xlen-1:0]        pc_out,
    output logic [xlen-1:0]        imm_out,
    output logic [rob_tag_len-1:0] dst_out
);

    rs_entry_t entries [num_entries]; // the only state besides the issue registers

    logic [age_width-1:0]   used_count; // number of valid entries
    logic [num_entries-1:0] hit1;       // first operand is filled by the current broadcast
    logic [num_entries-1:0] hit2;       // second operand is filled by the current broadcast
    logic [num_entries-1:0] ready_flags;
    logic [entry_width-1:0] sel_idx;    // oldest ready entry
    logic [age_width-1:0]   sel_age;
    logic [entry_width-1:0] free_idx;   // lowest free slot
    logic                   ld_hit1;
    logic                   ld_hit2;
    logic [age_width-1:0]   ld_age;

    // occupancy count, the station is full when every slot is taken
    always_comb begin
        used_count = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (entries[i].valid) begin
                used_count = used_count + 1'b1;
            end
        end
    end

    assign is_full = (used_count == age_width'(num_entries));

    // an operand already marked ready keeps its value even if an old tag is seen again
    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            hit1[i] = wakeup && entries[i].valid && !entries[i].ready1
                      && (entries[i].t1 == wakeup_tag);
            hit2[i] = wakeup && entries[i].valid && !entries[i].ready2
                      && (entries[i].t2 == wakeup_tag);
            ready_flags[i] = entries[i].valid
                             && (entries[i].ready1 || hit1[i])
                             && (entries[i].ready2 || hit2[i]);
        end
    end

    assign insn_ready = |ready_flags; // a same cycle wakeup counts as ready

    // pick the ready entry with the smallest age, ages of valid entries are unique
    always_comb begin
        sel_idx = '0;
        sel_age = '1; // larger than any legal age
        for (int i = 0; i < num_entries; i++) begin
            if (ready_flags[i] && (entries[i].bday < sel_age)) begin
                sel_idx = entry_width'(i);
                sel_age = entries[i].bday;
            end
        end
    end

    // scan downwards so the lowest free index wins
    always_comb begin
        free_idx = '0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = entry_width'(i);
            end
        end
    end

    // a new instruction may name the tag that is on the bus right now
    assign ld_hit1 = wakeup && !ready1 && (t1 == wakeup_tag);
    assign ld_hit2 = wakeup && !ready2 && (t2 == wakeup_tag);

    // when an entry leaves in the same cycle the newcomer slots in one step older
    assign ld_age = issue ? used_count - 1'b1 : used_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_entries; i++) begin
                entries[i].valid <= 1'b0;
            end
            start <= 1'b0;
        end else begin
            // capture the broadcast in every waiting operand that names its tag
            for (int i = 0; i < num_entries; i++) begin
                if (hit1[i]) begin
                    entries[i].ready1 <= 1'b1;
                    entries[i].v1     <= wakeup_value;
                end
                if (hit2[i]) begin
                    entries[i].ready2 <= 1'b1;
                    entries[i].v2     <= wakeup_value;
                end
            end

            // loads are dropped while full, the dispatcher retries
            if (load && !is_full) begin
                entries[free_idx] <= '{func:   func,
                                       t1:     t1,
                                       t2:     t2,
                                       dst:    dst,
                                       ready1: ready1 || ld_hit1,
                                       ready2: ready2 || ld_hit2,
                                       v1:     ld_hit1 ? wakeup_value : v1,
                                       v2:     ld_hit2 ? wakeup_value : v2,
                                       pc:     pc,
                                       imm:    imm,
                                       bday:   ld_age,
                                       valid:  1'b1};
            end

            start <= issue;
            if (issue) begin
                entries[sel_idx].valid <= 1'b0; // slot is free after this edge
                // everything loaded after the leaving entry moves one step older
                for (int i = 0; i < num_entries; i++) begin
                    if (entries[i].valid && (entries[i].bday > sel_age)) begin
                        entries[i].bday <= entries[i].bday - 1'b1;
                    end
                end
            end
        end
    end

    // issue registers carry payload only, start alone marks them valid
    always_ff @(posedge clk) begin
        if (issue) begin
            func_out <= entries[sel_idx].func;
            // bypass the broadcast for an operand that is woken in this very cycle
            v1_out   <= hit1[sel_idx] ? wakeup_value : entries[sel_idx].v1;
            v2_out   <= hit2[sel_idx] ? wakeup_value : entries[sel_idx].v2;
            pc_out   <= entries[sel_idx].pc;
            imm_out  <= entries[sel_idx].imm;
            dst_out  <= entries[sel_idx].dst;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ooo_pkg.sv
`default_nettype none

// shared sizes and types for the issue stage of the core
package ooo_pkg;

    localparam int num_entries = 4;            // station depth
    localparam int entry_width = 2;            // enough bits to index one entry
    localparam int age_width = entry_width + 1; // counts 0 up to num_entries inclusive
    localparam int rob_tag_len = 5;            // renamed register tag width
    localparam int xlen = 32;                  // integer data width

    // function codes understood by the alu
    typedef enum logic [2:0] {
        alu_add   = 3'd0,
        alu_sub   = 3'd1,
        alu_and   = 3'd2,
        alu_or    = 3'd3,
        alu_xor   = 3'd4,
        alu_slt   = 3'd5, // signed compare, result is 1 or 0
        alu_mul   = 3'd6, // the only two cycle operation
        alu_auipc = 3'd7  // pc plus imm, the operands are ignored
    } alu_func_t;

    // one waiting instruction inside the reservation station
    typedef struct packed {
        alu_func_t               func;
        logic [rob_tag_len-1:0]  t1;     // producer tag of the first operand
        logic [rob_tag_len-1:0]  t2;     // producer tag of the second operand
        logic [rob_tag_len-1:0]  dst;    // tag this instruction broadcasts
        logic                    ready1; // v1 holds the real operand value
        logic                    ready2; // v2 holds the real operand value
        logic [xlen-1:0]         v1;
        logic [xlen-1:0]         v2;
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         imm;
        logic [age_width-1:0]    bday;   // load order among valid entries, zero is the oldest
        logic                    valid;
    } rs_entry_t;

endpackage

`default_nettype wire
